/* tb.f */
logic/xc_pkg.sv
logic/line_sampler.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/xc_regs.sv
logic/correlator.sv
logic/frame_tx.sv
logic/xc_firmware.sv
sim/xc_asserts.sv
sim/tb_xc.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_xc -o tb_xc
	@out="$$(./obj_dir/tb_xc +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

/* sim/tb_xc.sv */
// Testbench for the correlator top level with host UART model, line stimulus and frame checks.
`timescale 1ns/1ps

module tb_xc;

    localparam int NUM_LINES   = 4;
    localparam int BIT_CLKS    = 16;
    localparam int NUM_COUNTS  = NUM_LINES + NUM_LINES * (NUM_LINES - 1) / 2;
    localparam int FRAME_BYTES = 1 + 2 * NUM_COUNTS;
    // One frame, with slack per byte for the framer steps.
    localparam int FRAME_CLKS  = FRAME_BYTES * (10 * BIT_CLKS + 8);
    localparam int HOST_CLKS   = 10 * BIT_CLKS + 1;
    // Windows of 4+4+2+2+2 units, 5 frames, 11 host bytes, 1100 idle cycles, margin.
    localparam int RUN_CLKS    = 14 * 256 + 5 * FRAME_CLKS + 11 * HOST_CLKS + 1100 + 2000;

    // Host command bytes and frame header, as ASCII.
    localparam logic [7:0] CMD_L = "L";
    localparam logic [7:0] CMD_S = "S";
    localparam logic [7:0] HDR   = "X";

    logic                 clki;
    logic                 rst;
    logic                 rx;
    logic                 tx;
    logic [NUM_LINES-1:0] line_in;
    logic [NUM_LINES-1:0] line_out;

    int                   seed;
    int                   errors;
    int                   tests;
    // Window length the DUT should hold.
    logic [7:0]           cur_len;
    // Reference counts, autos then pairs in frame order.
    logic [15:0]          exp_count [NUM_COUNTS];
    logic [NUM_LINES-1:0] exp_flags;
    logic [7:0]           frame [FRAME_BYTES];

    xc_firmware #(.NUM_LINES(NUM_LINES), .CLKS_PER_BIT(BIT_CLKS)) i_dut (
        .clki(clki), .rst(rst), .rx(rx), .tx(tx), .line_in(line_in), .line_out(line_out)
    );

    initial begin
        clki = 1'b0;
        forever #50 clki = ~clki;
    end

    // Watchdog.
    initial begin
        repeat (RUN_CLKS) @(posedge clki);
        $display("timeout: the tests did not finish within %0d cycles", RUN_CLKS);
        $display("Regression failed");
        $finish;
    end

    // Inputs change 10 ns after the rising edge.
    task automatic step();
        @(posedge clki);
        #10;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) step();
    endtask

    task automatic expect_value(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Host side 8N1, LSB first.
    task automatic send_host_byte(input logic [7:0] data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};
        step();
        for (int b = 0; b < 10; b++) begin
            rx = bits[b];
            repeat (BIT_CLKS) step();
        end
    endtask

    // Samples tx at mid-bit on falling clock edges.
    task automatic receive_byte(output logic [7:0] data);
        @(negedge clki);
        while (tx !== 1'b0) begin
            @(negedge clki);
        end
        repeat (BIT_CLKS / 2) @(negedge clki);
        for (int b = 0; b < 8; b++) begin
            repeat (BIT_CLKS) @(negedge clki);
            data[b] = tx;
        end
        repeat (BIT_CLKS) @(negedge clki);
        assert (tx === 1'b1) else begin
            $display("stop bit of a frame byte was low at %0t ns", $time);
            errors++;
        end
    endtask

    task automatic watch_tx_idle(input int n);
        for (int c = 0; c < n; c++) begin
            @(negedge clki);
            expect_value("tx", 16'd1, 16'(tx));
        end
    endtask

    task automatic clear_model();
        for (int k = 0; k < NUM_COUNTS; k++) begin
            exp_count[k] = '0;
        end
        exp_flags = '0;
    endtask

    // Random edges for n cycles on the lines in mask, counted as they are driven.
    // Single mode raises one line at a time, else any subset rises together.
    task automatic drive_pulses(input int n, input logic [NUM_LINES-1:0] mask, input bit single);
        logic [NUM_LINES-1:0] next;
        logic [NUM_LINES-1:0] rise;
        int                   p;
        for (int c = 0; c < n; c++) begin
            if (line_in != '0) begin
                next = '0;
            end else if (single) begin
                next = (NUM_LINES'(1) << ($unsigned($random(seed)) % NUM_LINES)) & mask;
            end else begin
                next = NUM_LINES'($random(seed)) & mask;
            end
            rise = next & ~line_in;
            p = NUM_LINES;
            for (int i = 0; i < NUM_LINES; i++) begin
                exp_count[i] = exp_count[i] + 16'(rise[i]);
                exp_flags[i] = exp_flags[i] | rise[i];
                // Pair (i, j) in frame order.
                for (int j = i + 1; j < NUM_LINES; j++) begin
                    exp_count[p] = exp_count[p] + 16'(rise[i] & rise[j]);
                    p++;
                end
            end
            line_in = next;
            step();
        end
        line_in = '0;
        step();
    endtask

    // Edges stay 50 cycles clear of both window ends.
    task automatic run_capture(input logic [NUM_LINES-1:0] mask, input bit single);
        clear_model();
        send_host_byte(CMD_S);
        wait_cycles(50);
        // Capture has cleared the flags.
        expect_value("line_out", 16'd0, 16'(line_out));
        drive_pulses(int'(cur_len) * 256 - 100, mask, single);
    endtask

    task automatic check_frame();
        logic [7:0] data;
        for (int b = 0; b < FRAME_BYTES; b++) begin
            receive_byte(data);
            frame[b] = data;
        end
        expect_value("frame header", 16'(HDR), 16'(frame[0]));
        // High byte first.
        for (int k = 0; k < NUM_COUNTS; k++) begin
            expect_value($sformatf("frame count %0d", k), exp_count[k],
                         {frame[1 + 2 * k], frame[2 + 2 * k]});
        end
        expect_value("line_out", 16'(exp_flags), 16'(line_out));
    endtask

    task automatic report_test(input string label, input int mark);
        tests++;
        $display("test %0d %s: %s", tests, label, (errors == mark) ? "ok" : "mismatch");
    endtask

    initial begin
        int mark;
        seed    = 32'hf1c48543;
        errors  = 0;
        tests   = 0;
        cur_len = 8'd4;
        rst     = 1'b1;
        rx      = 1'b1;
        line_in = '0;
        clear_model();
        repeat (2) @(posedge clki);
        #10;
        rst = 1'b0;

        // No frame without a command.
        mark = errors;
        watch_tx_idle(300);
        expect_value("line_out", 16'd0, 16'(line_out));
        report_test("idle after reset", mark);

        mark = errors;
        run_capture(4'b1111, 1'b1);
        check_frame();
        report_test("single line pulses", mark);

        // Line 2 left quiet so its pairs read zero.
        mark = errors;
        run_capture(4'b1011, 1'b0);
        check_frame();
        report_test("coincident pulses", mark);

        // Shorter window, plus a start that arrives while busy.
        mark = errors;
        send_host_byte(CMD_L);
        send_host_byte(8'd2);
        cur_len = 8'd2;
        fork
            run_capture(4'b1111, 1'b0);
            begin
                wait_cycles(300);
                send_host_byte(CMD_S);
            end
        join
        check_frame();
        watch_tx_idle(400);
        report_test("new length and refused start", mark);

        mark = errors;
        send_host_byte(8'h41);
        send_host_byte(8'h00);
        send_host_byte(8'ha5);
        watch_tx_idle(400);
        run_capture(4'b0101, 1'b1);
        check_frame();
        // Flags of lines 0 and 2 go at this capture.
        run_capture(4'b0010, 1'b1);
        check_frame();
        report_test("unknown bytes and line flags", mark);

        $display("%0d tests, %0d errors, %0d assertion failures",
                 tests, errors, i_dut.u_chk.fail_count);
        if (errors == 0 && i_dut.u_chk.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim/xc_asserts.sv */
// Bound checks on reset state, transmitter idle level and line flags.
`timescale 1ns/1ps

module xc_asserts #(
    parameter int NUM_LINES = 4
) (
    input logic                 clki,
    input logic                 rst,
    input logic                 tx,
    input logic                 tx_busy,
    input logic                 capture,
    input logic [NUM_LINES-1:0] line_out
);

    // Failures per property.
    int unsigned reset_fails = 0;
    int unsigned idle_fails  = 0;
    int unsigned flag_fails  = 0;
    // Total, read by the testbench.
    int unsigned fail_count;

    assign fail_count = reset_fails + idle_fails + flag_fails;

    // One reset cycle puts tx and the flags at rest.
    reset_idle: assert property (@(posedge clki) rst |=> (tx && line_out == '0))
        else begin
            $error("tx or line_out not at rest after a reset cycle");
            reset_fails++;
        end

    // Line is high whenever the transmitter has no byte.
    tx_idle_high: assert property (@(posedge clki) disable iff (rst) !tx_busy |-> tx)
        else begin
            $error("tx low while the transmitter is idle");
            idle_fails++;
        end

    // A set flag only drops on a capture.
    flags_hold: assert property (@(posedge clki) disable iff (rst)
        (|($past(line_out) & ~line_out)) |-> $past(capture))
        else begin
            $error("line_out bit cleared without a capture");
            flag_fails++;
        end

endmodule

bind xc_firmware xc_asserts #(.NUM_LINES(NUM_LINES)) u_chk (
    .clki(clki), .rst(rst), .tx(tx), .tx_busy(tx_busy),
    .capture(capture), .line_out(line_out)
);

/* logic/xc_firmware.sv */
// Cross-correlator top level joining sampler, command registers, correlator, framer and UART.
`timescale 1ns/1ps

module xc_firmware #(
    parameter int NUM_LINES     = 4,
    parameter int CLK_FREQUENCY = 10000000,
    parameter int BAUD_RATE     = 57600,
    parameter int CLKS_PER_BIT  = CLK_FREQUENCY / BAUD_RATE
) (
    input  logic                 clki,
    input  logic                 rst,
    input  logic                 rx,
    output logic                 tx,
    input  logic [NUM_LINES-1:0] line_in,
    output logic [NUM_LINES-1:0] line_out
);

    import xc_pkg::*;

    localparam int NUM_COUNTS = NUM_LINES + pair_count(NUM_LINES);

    logic [NUM_LINES-1:0]               pulse;
    byte_t                              rx_data;
    logic                               rx_valid;
    len_t                               integ_len;
    logic                               capture;
    logic                               busy;
    logic                               done;
    logic [NUM_COUNTS*$bits(count_t)-1:0] counts;
    byte_t                              tx_data;
    logic                               tx_start;
    logic                               tx_busy;

    // Photon pulse front end.
    line_sampler #(.NUM_LINES(NUM_LINES)) u_sampler (
        .clki(clki), .rst(rst), .line_in(line_in), .pulse(pulse)
    );

    // Host commands in.
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clki(clki), .rst(rst), .rx(rx), .rx_data(rx_data), .rx_valid(rx_valid)
    );

    xc_regs u_regs (
        .clki(clki), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid),
        .busy(busy), .integ_len(integ_len), .capture(capture)
    );

    correlator #(.NUM_LINES(NUM_LINES)) u_corr (
        .clki(clki), .rst(rst), .pulse(pulse), .capture(capture),
        .integ_len(integ_len), .busy(busy), .done(done), .counts(counts),
        .line_out(line_out)
    );

    // Results out.
    frame_tx #(.NUM_LINES(NUM_LINES)) u_framer (
        .clki(clki), .rst(rst), .done(done), .counts(counts),
        .tx_busy(tx_busy), .tx_data(tx_data), .tx_start(tx_start)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clki(clki), .rst(rst), .tx_data(tx_data), .tx_start(tx_start),
        .tx(tx), .tx_busy(tx_busy)
    );

endmodule

/* logic/frame_tx.sv */
// Result framer that sends header and big-endian counts to the UART transmitter.
`timescale 1ns/1ps

module frame_tx #(
    parameter int  NUM_LINES  = 4,
    localparam int NUM_COUNTS = NUM_LINES + xc_pkg::pair_count(NUM_LINES)
) (
    input  logic                                          clki,
    input  logic                                          rst,
    input  logic                                          done,
    input  logic [NUM_COUNTS*$bits(xc_pkg::count_t)-1:0] counts,
    input  logic                                          tx_busy,
    output xc_pkg::byte_t                                 tx_data,
    output logic                                          tx_start
);

    import xc_pkg::*;

    // Header plus two bytes per count.
    localparam int FRAME_BYTES = 1 + 2 * NUM_COUNTS;
    localparam int IDX_W       = $clog2(FRAME_BYTES);

    typedef enum logic [1:0] {
        FR_IDLE,
        FR_LOAD,
        FR_SEND,
        FR_WAIT
    } fr_state_t;

    fr_state_t                              state;
    logic [IDX_W-1:0]                       idx;
    // Byte offset past the header.
    logic [IDX_W-1:0]                       ofs;
    // Bit position of the byte, entry * 16 plus 8 for the high byte.
    logic [IDX_W+2:0]                       pos;
    logic [NUM_COUNTS*$bits(count_t)-1:0]   snap;

    assign ofs      = idx - 1'b1;
    assign pos      = {ofs[IDX_W-1:1], ~ofs[0], 3'b000};
    assign tx_start = (state == FR_SEND);

    always_ff @(posedge clki) begin
        if (rst) begin
            state <= FR_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                FR_IDLE: begin
                    idx <= '0;
                    // A done strobe is only seen here, so one during a frame is lost.
                    if (done) begin
                        state <= FR_LOAD;
                    end
                end
                FR_LOAD: state <= FR_SEND;
                FR_SEND: state <= FR_WAIT;
                FR_WAIT: begin
                    // Transmitter back-pressure.
                    if (!tx_busy) begin
                        if (idx == IDX_W'(FRAME_BYTES - 1)) begin
                            state <= FR_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= FR_LOAD;
                        end
                    end
                end
                default: state <= FR_IDLE;
            endcase
        end
    end

    // Counts are frozen for the whole frame.
    always_ff @(posedge clki) begin
        if (state == FR_IDLE && done) begin
            snap <= counts;
        end
        if (state == FR_LOAD) begin
            tx_data <= (idx == '0) ? FRAME_HEADER : snap[pos +: 8];
        end
    end

endmodule

/* logic/correlator.sv */
// Integration timer, auto and cross coincidence counters, and line activity flags.
`timescale 1ns/1ps

module correlator #(
    parameter int  NUM_LINES  = 4,
    localparam int NUM_COUNTS = NUM_LINES + xc_pkg::pair_count(NUM_LINES)
) (
    input  logic                                          clki,
    input  logic                                          rst,
    input  logic [NUM_LINES-1:0]                          pulse,
    input  logic                                          capture,
    input  xc_pkg::len_t                                  integ_len,
    output logic                                          busy,
    output logic                                          done,
    output logic [NUM_COUNTS*$bits(xc_pkg::count_t)-1:0] counts,
    output logic [NUM_LINES-1:0]                          line_out
);

    import xc_pkg::*;

    localparam int CW      = $bits(count_t);
    localparam int TIMER_W = $bits(len_t) + 8;

    logic [TIMER_W-1:0]    timer;
    // Last cycle of the window, fixed at capture.
    logic [TIMER_W-1:0]    win_last;
    // Increment request per counter, autos then pairs.
    logic [NUM_COUNTS-1:0] inc;

    // Window of integ_len * 256 cycles.
    // A length of zero wraps to the longest window.
    always_ff @(posedge clki) begin
        if (capture) begin
            win_last <= {len_t'(integ_len - 1'b1), 8'hff};
        end
    end

    always_ff @(posedge clki) begin
        if (rst) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            timer <= '0;
        end else begin
            done <= 1'b0;
            if (capture) begin
                busy  <= 1'b1;
                timer <= '0;
            end else if (busy) begin
                timer <= timer + 1'b1;
                if (timer == win_last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Auto terms are the line pulses themselves.
    // Cross terms need both pulses in the same cycle.
    for (genvar i = 0; i < NUM_LINES; i++) begin : g_auto
        assign inc[i] = pulse[i];
        for (genvar j = i + 1; j < NUM_LINES; j++) begin : g_cross
            // Pairs ordered (0,1), (0,2) ... (N-2,N-1).
            localparam int P = NUM_LINES + i * NUM_LINES - i * (i + 1) / 2 + (j - i - 1);
            assign inc[P] = pulse[i] & pulse[j];
        end
    end

    // One saturating counter per entry.
    for (genvar k = 0; k < NUM_COUNTS; k++) begin : g_cnt
        count_t cnt;

        always_ff @(posedge clki) begin
            if (capture) begin
                cnt <= '0;
            end else if (busy && inc[k] && cnt != '1) begin
                cnt <= cnt + 1'b1;
            end
        end

        assign counts[k*CW +: CW] = cnt;
    end

    // Flag goes up on the first pulse of a line and stays until the next capture.
    always_ff @(posedge clki) begin
        if (rst || capture) begin
            line_out <= '0;
        end else if (busy) begin
            line_out <= line_out | pulse;
        end
    end

endmodule

/* logic/xc_regs.sv */
// Host command decoder with integration length register and capture strobe.
`timescale 1ns/1ps

module xc_regs (
    input  logic          clki,
    input  logic          rst,
    input  xc_pkg::byte_t rx_data,
    input  logic          rx_valid,
    input  logic          busy,
    output xc_pkg::len_t  integ_len,
    output logic          capture
);

    import xc_pkg::*;

    // Waiting for a command, or for the length argument.
    typedef enum logic {
        DEC_CMD,
        DEC_LEN
    } dec_state_t;

    dec_state_t state;

    always_ff @(posedge clki) begin
        if (rst) begin
            state     <= DEC_CMD;
            integ_len <= LEN_DEFAULT;
            capture   <= 1'b0;
        end else begin
            capture <= 1'b0;
            if (rx_valid) begin
                case (state)
                    DEC_CMD: begin
                        // Start is refused while a window runs.
                        if (rx_data == CMD_START) begin
                            capture <= !busy;
                        end else if (rx_data == CMD_LEN) begin
                            state <= DEC_LEN;
                        end
                        // Anything else is ignored
                    end
                    DEC_LEN: begin
                        // Argument byte is taken as is.
                        integ_len <= rx_data;
                        state     <= DEC_CMD;
                    end
                    default: state <= DEC_CMD;
                endcase
            end
        end
    end

endmodule

/* logic/uart_tx.sv */
// 8N1 UART transmitter with start strobe and busy level.
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic          clki,
    input  logic          rst,
    input  xc_pkg::byte_t tx_data,
    input  logic          tx_start,
    output logic          tx,
    output logic          tx_busy
);

    import xc_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t        state;
    byte_t            shreg;
    logic [CNT_W-1:0] timer;
    logic [2:0]       bit_idx;
    logic             bit_end;

    assign bit_end = (timer == CNT_W'(CLKS_PER_BIT - 1));
    assign tx_busy = (state != TX_IDLE);

    always_ff @(posedge clki) begin
        if (rst) begin
            state   <= TX_IDLE;
            timer   <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else begin
            timer <= bit_end ? '0 : timer + 1'b1;
            case (state)
                TX_IDLE: begin
                    timer   <= '0;
                    bit_idx <= '0;
                    if (tx_start) begin
                        // Start bit.
                        tx    <= 1'b0;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        tx    <= shreg[0];
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            // Stop bit.
                            tx    <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            tx <= shreg[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Byte is taken at the start strobe and shifted out LSB first.
    always_ff @(posedge clki) begin
        if (state == TX_IDLE && tx_start) begin
            shreg <= tx_data;
        end else if (state == TX_DATA && bit_end) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

/* logic/uart_rx.sv */
// 8N1 UART receiver with a one-cycle byte strobe.
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic          clki,
    input  logic          rst,
    input  logic          rx,
    output xc_pkg::byte_t rx_data,
    output logic          rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] timer;
    logic [2:0]       bit_idx;
    logic             half_end;
    logic             bit_end;

    // Middle of the start bit.
    assign half_end = (timer == CNT_W'(CLKS_PER_BIT / 2 - 1));
    // Middle of a data or stop bit.
    assign bit_end  = (timer == CNT_W'(CLKS_PER_BIT - 1));

    // Idle line is high.
    always_ff @(posedge clki) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clki) begin
        if (rst) begin
            state    <= RX_IDLE;
            timer    <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            timer    <= timer + 1'b1;
            case (state)
                RX_IDLE: begin
                    timer   <= '0;
                    bit_idx <= '0;
                    // Falling edge marks the start bit.
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_end) begin
                        timer <= '0;
                        // Glitch shorter than half a bit is dropped.
                        state <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        timer   <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        // Framing error, no strobe.
                        rx_valid <= rx_sync;
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top.
    always_ff @(posedge clki) begin
        if (state == RX_DATA && bit_end) begin
            rx_data <= {rx_sync, rx_data[7:1]};
        end
    end

endmodule

/* logic/line_sampler.sv */
// Input line synchronizers and rising-edge pulse detection.
`timescale 1ns/1ps

module line_sampler #(
    parameter int NUM_LINES = 4
) (
    input  logic                 clki,
    input  logic                 rst,
    input  logic [NUM_LINES-1:0] line_in,
    output logic [NUM_LINES-1:0] pulse
);

    // First synchronizer stage, may go metastable.
    logic [NUM_LINES-1:0] meta;
    // Second stage, safe to use in the clock domain.
    logic [NUM_LINES-1:0] sync;
    // Previous synchronized value for edge detection.
    logic [NUM_LINES-1:0] prev;

    // Edge on line_in shows on pulse three cycles later.
    always_ff @(posedge clki) begin
        if (rst) begin
            meta  <= '0;
            sync  <= '0;
            prev  <= '0;
            pulse <= '0;
        end else begin
            meta  <= line_in;
            sync  <= meta;
            prev  <= sync;
            // One-cycle strobe where the line rose.
            pulse <= sync & ~prev;
        end
    end

endmodule

/* logic/xc_pkg.sv */
// Count, byte and length types, host command codes, frame header and pair count helper.
package xc_pkg;

    // Width of one correlation count.
    localparam int COUNT_W = 16;

    // One correlation count, saturating at its maximum.
    typedef logic [COUNT_W-1:0] count_t;

    // One UART byte.
    typedef logic [7:0] byte_t;

    // Integration length in units of 256 clock cycles.
    typedef logic [7:0] len_t;

    // Host command: the next byte is the new length.
    localparam byte_t CMD_LEN = 8'h4C;

    // Host command: start one capture.
    localparam byte_t CMD_START = 8'h53;

    // First byte of every result frame.
    localparam byte_t FRAME_HEADER = 8'h58;

    // Integration length after reset.
    localparam len_t LEN_DEFAULT = 8'd4;

    // Number of distinct line pairs (i, j) with i < j.
    function automatic int pair_count(input int lines);
        return lines * (lines - 1) / 2;
    endfunction

endpackage
